/* compile.f */
rtl/dcache_pkg.sv
rtl/line_xfer_if.sv
rtl/dcache_tag_store.sv
rtl/dcache_data_store.sv
rtl/dcache_ctrl.sv
rtl/dcache_axi_burst.sv
rtl/dcache_top.sv
bench/dcache_assert.sv
bench/tb_dcache.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_dcache -o Vtb_dcache -f compile.f

./obj_dir/Vtb_dcache > sim.log 2>&1 || true
cat sim.log

if grep -q "=== FAIL ===" sim.log || ! grep -q "=== PASS ===" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

/* bench/tb_dcache.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_dcache import dcache_pkg::*; ();

    localparam int OFFSET_BITS = 5;
    localparam int INDEX_BITS  = 7;
    localparam int SEED        = 32'h303e;
    localparam int RANDOM_OPS  = 400;
    localparam int WAIT_LIMIT  = 2000;
    localparam int IDLE_LIMIT  = 200000;

    logic clk = 1'b0;
    logic rst;
    logic req;
    logic wr;
    logic [ADDR_W-1:0] addr;
    word_t wdata;
    logic [3:0] wstrb;
    logic done;
    word_t rdata;
    logic [ADDR_W-1:0] araddr;
    logic [7:0] arlen;
    logic arvalid;
    logic arready;
    word_t rdata_m;
    logic rlast;
    logic rvalid;
    logic rready;
    logic [ADDR_W-1:0] awaddr;
    logic [7:0] awlen;
    logic awvalid;
    logic awready;
    word_t wdata_m;
    logic wlast;
    logic wvalid;
    logic wready;
    logic bvalid;
    logic bready;

    // memory behind the bus, and what the core expects to see
    word_t mem_words [logic [29:0]];
    word_t shadow [logic [29:0]];

    logic cur_wr;
    word_t cur_exp;
    int ar_count = 0;
    int aw_count = 0;
    int ar_order = 0;
    int aw_order = 0;
    int events = 0;
    logic [ADDR_W-1:0] last_araddr;
    logic [ADDR_W-1:0] last_awaddr;
    logic [7:0] last_arlen;

    dcache_top #(.OFFSET_BITS(OFFSET_BITS), .INDEX_BITS(INDEX_BITS)) UUT (.*);

    always #10 clk = ~clk;

    function automatic word_t fill_word(logic [29:0] widx);
        return {2'b00, widx[13:0], widx[29:14]} ^ 32'hc3a5_5a3c ^ {2'b00, widx};
    endfunction

    function automatic word_t mem_read(logic [29:0] widx);
        if (mem_words.exists(widx)) return mem_words[widx];
        return fill_word(widx);
    endfunction

    // expected load value
    function automatic word_t ref_load(logic [ADDR_W-1:0] a);
        if (shadow.exists(a[31:2])) return shadow[a[31:2]];
        return fill_word(a[31:2]);
    endfunction

    task automatic shadow_store(logic [ADDR_W-1:0] a, word_t d, logic [3:0] s);
        word_t cur;
        cur = ref_load(a);
        for (int b = 0; b < 4; b++) begin
            if (s[b]) cur[8*b +: 8] = d[8*b +: 8];
        end
        shadow[a[31:2]] = cur;
    endtask

    task automatic fail_now(string msg);
        $display("Fail %0t: %s", $time, msg);
        $display("=== FAIL ===");
        $fatal(1, "check failed");
    endtask

    task automatic timeout_now(string what);
        $display("timed out while waiting for %s", what);
        $display("=== FAIL ===");
        $fatal(1, "timeout");
    endtask

    task automatic check_word(word_t got, word_t exp, string what);
        if (got !== exp) fail_now($sformatf("%s: got %08h, expected %08h", what, got, exp));
    endtask

    task automatic check_addr(logic [ADDR_W-1:0] got, logic [ADDR_W-1:0] exp, string what);
        if (got !== exp) fail_now($sformatf("%s: got %08h, expected %08h", what, got, exp));
    endtask

    task automatic check_len(logic [7:0] got, logic [7:0] exp, string what);
        if (got !== exp) fail_now($sformatf("%s: got %0d, expected %0d", what, got, exp));
    endtask

    task automatic check_count(int got, int exp, string what);
        if (got != exp) fail_now($sformatf("%s: got %0d, expected %0d", what, got, exp));
    endtask

    task automatic check_flags(logic [5:0] got, logic [5:0] exp, string what);
        if (got !== exp) fail_now($sformatf("%s: got %b, expected %b", what, got, exp));
    endtask

    // one core request, held until done
    task automatic access(input logic w, input logic [ADDR_W-1:0] a, input word_t d,
                          input logic [3:0] s, output int cycles);
        int n;
        n = 0;
        cur_wr = w;
        cur_exp = ref_load(a);
        @(posedge clk);
        req <= 1'b1;
        wr <= w;
        addr <= a;
        wdata <= d;
        wstrb <= s;
        do begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) timeout_now("done from the cache");
        end while (done !== 1'b1);
        @(posedge clk);
        req <= 1'b0;
        wr <= 1'b0;
        if (w) shadow_store(a, d, s);
        cycles = n;
    endtask

    always @(negedge clk) begin
        if (!rst && done === 1'b1 && !cur_wr) begin
            check_word(rdata, cur_exp, $sformatf("load from %08h", addr));
        end
    end

    initial begin : read_responder
        logic [29:0] base;
        int len;
        int n;
        forever begin
            n = 0;
            do begin
                @(negedge clk);
                n++;
                if (n > IDLE_LIMIT) timeout_now("a read burst");
            end while (arvalid !== 1'b1);
            repeat ($urandom_range(0, 3)) @(posedge clk);
            @(posedge clk);
            arready <= 1'b1;
            @(negedge clk);
            // a refill always fetches the line of the pending request
            check_addr(araddr, {addr[ADDR_W-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}},
                       "refill line address");
            base = araddr[31:2];
            len = int'(arlen);
            last_araddr = araddr;
            last_arlen = arlen;
            ar_count++;
            events++;
            ar_order = events;
            @(posedge clk);
            arready <= 1'b0;
            for (int i = 0; i <= len; i++) begin
                repeat ($urandom_range(0, 2)) @(posedge clk);
                @(posedge clk);
                rvalid <= 1'b1;
                rdata_m <= mem_read(base + 30'(i));
                rlast <= (i == len);
                n = 0;
                do begin
                    @(negedge clk);
                    n++;
                    if (n > WAIT_LIMIT) timeout_now("rready");
                end while (rready !== 1'b1);
                @(posedge clk);
                rvalid <= 1'b0;
                rlast <= 1'b0;
            end
        end
    end

    initial begin : write_responder
        logic [29:0] base;
        int len;
        int n;
        forever begin
            n = 0;
            do begin
                @(negedge clk);
                n++;
                if (n > IDLE_LIMIT) timeout_now("a write burst");
            end while (awvalid !== 1'b1);
            repeat ($urandom_range(0, 3)) @(posedge clk);
            @(posedge clk);
            awready <= 1'b1;
            @(negedge clk);
            // the victim sits in the set of the pending request
            check_addr(awaddr, {awaddr[ADDR_W-1:OFFSET_BITS+INDEX_BITS],
                                addr[OFFSET_BITS+INDEX_BITS-1:OFFSET_BITS],
                                {OFFSET_BITS{1'b0}}},
                       "write-back set and alignment");
            check_len(awlen, 8'd7, "write burst length");
            base = awaddr[31:2];
            len = int'(awlen);
            last_awaddr = awaddr;
            aw_count++;
            events++;
            aw_order = events;
            @(posedge clk);
            awready <= 1'b0;
            for (int i = 0; i <= len; i++) begin
                repeat ($urandom_range(0, 2)) @(posedge clk);
                @(posedge clk);
                wready <= 1'b1;
                n = 0;
                do begin
                    @(negedge clk);
                    n++;
                    if (n > WAIT_LIMIT) timeout_now("wvalid");
                end while (wvalid !== 1'b1);
                check_word(wdata_m, ref_load({base + 30'(i), 2'b00}), "write-back beat");
                check_count(int'(wlast), int'(i == len), "wlast on write beat");
                mem_words[base + 30'(i)] = wdata_m;
                @(posedge clk);
                wready <= 1'b0;
            end
            repeat ($urandom_range(0, 3)) @(posedge clk);
            @(posedge clk);
            bvalid <= 1'b1;
            n = 0;
            do begin
                @(negedge clk);
                n++;
                if (n > WAIT_LIMIT) timeout_now("bready");
            end while (bready !== 1'b1);
            @(posedge clk);
            bvalid <= 1'b0;
        end
    end

    initial begin
        int lat;
        int ar0;
        int aw0;
        logic [ADDR_W-1:0] a;
        void'($urandom(SEED));
        rst <= 1'b1;
        req <= 1'b0;
        wr <= 1'b0;
        addr <= '0;
        wdata <= '0;
        wstrb <= '0;
        arready <= 1'b0;
        rvalid <= 1'b0;
        rdata_m <= '0;
        rlast <= 1'b0;
        awready <= 1'b0;
        wready <= 1'b0;
        bvalid <= 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_flags({done, arvalid, awvalid, wvalid, rready, bready}, 6'b0,
                    "handshake outputs after reset");

        // first load refills one line
        ar0 = ar_count;
        aw0 = aw_count;
        access(1'b0, 32'h0000_0044, '0, 4'h0, lat);
        check_count(ar_count, ar0 + 1, "read bursts on first load");
        check_count(aw_count, aw0, "write bursts on first load");
        check_addr(last_araddr, 32'h0000_0040, "refill address");
        check_len(last_arlen, 8'd7, "refill length");

        // hit in the same line
        access(1'b0, 32'h0000_0048, '0, 4'h0, lat);
        check_count(ar_count, ar0 + 1, "read bursts on load hit");
        check_count(aw_count, aw0, "write bursts on load hit");
        check_count(lat, 3, "load hit latency");

        // partial store hit, then read back
        access(1'b1, 32'h0000_0048, 32'hdead_beef, 4'b0101, lat);
        access(1'b0, 32'h0000_0048, '0, 4'h0, lat);
        check_count(ar_count, ar0 + 1, "read bursts on store hit");
        check_count(aw_count, aw0, "write bursts on store hit");

        // two dirty ways in set 5, third tag evicts the older one
        access(1'b1, 32'h0001_00a0, 32'h1111_2222, 4'hf, lat);
        access(1'b1, 32'h0002_00a4, 32'h3333_4444, 4'hc, lat);
        ar0 = ar_count;
        aw0 = aw_count;
        access(1'b0, 32'h0003_00a8, '0, 4'h0, lat);
        check_count(aw_count, aw0 + 1, "write bursts on dirty eviction");
        check_count(ar_count, ar0 + 1, "read bursts on dirty eviction");
        check_addr(last_awaddr, 32'h0001_00a0, "victim write-back address");
        if (aw_order > ar_order) fail_now("refill started before the write-back");

        // store miss into clean set 9, then force it out and read it back
        ar0 = ar_count;
        access(1'b1, 32'h0004_012c, 32'h1234_5678, 4'b1110, lat);
        check_count(ar_count, ar0 + 1, "read bursts on store miss");
        access(1'b0, 32'h0005_0120, '0, 4'h0, lat);
        aw0 = aw_count;
        access(1'b0, 32'h0006_0120, '0, 4'h0, lat);
        check_count(aw_count, aw0 + 1, "write bursts evicting the stored line");
        check_addr(last_awaddr, 32'h0004_0120, "stored line write-back address");
        access(1'b0, 32'h0004_012c, '0, 4'h0, lat);

        // four tags over four sets, two ways each
        for (int i = 0; i < RANDOM_OPS; i++) begin
            a = {12'h000, 4'($urandom_range(1, 4)), 9'h000, 2'($urandom_range(0, 3)),
                 3'($urandom_range(0, 7)), 2'b00};
            access(1'($urandom_range(0, 1)), a, $urandom, 4'($urandom_range(1, 15)), lat);
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/dcache_assert.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_assert import dcache_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              req,
    input  logic [ADDR_W-1:0] addr,
    input  logic              done,
    input  logic              arvalid,
    input  logic              arready,
    input  logic [ADDR_W-1:0] araddr,
    input  logic              awvalid,
    input  logic              awready,
    input  logic [ADDR_W-1:0] awaddr,
    input  logic              wvalid,
    input  logic              wready,
    input  logic              wlast,
    input  ctrl_state_t       state,
    input  logic [ADDR_W-3:0] req_word_addr
);

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("arvalid or araddr changed before arready");

    aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else $error("awvalid or awaddr changed before awready");

    w_hold: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid && $stable(wlast))
        else $error("wvalid or wlast changed before wready");

    done_pulse: assert property (@(posedge clk) disable iff (rst)
        done |=> !done)
        else $error("done high for two cycles");

    // outside IDLE the latched request is the one the core still holds
    sample_idle: assert property (@(posedge clk) disable iff (rst)
        state != IDLE && req |-> req_word_addr == addr[ADDR_W-1:2])
        else $error("request sampled outside IDLE");

endmodule

bind dcache_top dcache_assert u_assert (
    .state         (u_ctrl.state),
    .req_word_addr (u_ctrl.req_word_addr),
    .*
);

`default_nettype wire

/* rtl/dcache_top.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_top import dcache_pkg::*; #(
    parameter int OFFSET_BITS = 5,
    parameter int INDEX_BITS  = 7
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              req,
    input  logic              wr,
    input  logic [ADDR_W-1:0] addr,
    input  word_t             wdata,
    input  logic [3:0]        wstrb,
    output logic              done,
    output word_t             rdata,
    output logic [ADDR_W-1:0] araddr,
    output logic [7:0]        arlen,
    output logic              arvalid,
    input  logic              arready,
    input  word_t             rdata_m,
    input  logic              rlast,
    input  logic              rvalid,
    output logic              rready,
    output logic [ADDR_W-1:0] awaddr,
    output logic [7:0]        awlen,
    output logic              awvalid,
    input  logic              awready,
    output word_t             wdata_m,
    output logic              wlast,
    output logic              wvalid,
    input  logic              wready,
    input  logic              bvalid,
    output logic              bready
);

    localparam int TAG_W  = ADDR_W - OFFSET_BITS - INDEX_BITS;
    localparam int RAM_AW = INDEX_BITS + OFFSET_BITS - 2;

    logic [INDEX_BITS-1:0] rd_index;
    logic [INDEX_BITS-1:0] upd_index;
    logic [TAG_W-1:0]      rd_tag;
    logic [TAG_W-1:0]      victim_tag;
    logic [TAG_W-1:0]      upd_tag;
    logic                  hit;
    logic                  hit_way;
    logic                  victim_way;
    logic                  victim_dirty;
    logic                  upd_en;
    logic                  upd_way;
    logic                  upd_fill;
    logic                  upd_dirty;
    logic [RAM_AW-1:0]     rd_addr;
    logic [RAM_AW-1:0]     wr_addr;
    logic                  rd_way;
    logic                  we;
    logic                  wr_way;
    word_t                 rd_word;
    word_t                 wr_word;
    logic [3:0]            wr_strb;

    line_xfer_if #(.OFFSET_BITS(OFFSET_BITS), .INDEX_BITS(INDEX_BITS)) xfer ();

    dcache_ctrl #(.OFFSET_BITS(OFFSET_BITS), .INDEX_BITS(INDEX_BITS)) u_ctrl (
        .xfer (xfer.ctrl),
        .*
    );

    dcache_tag_store #(.OFFSET_BITS(OFFSET_BITS), .INDEX_BITS(INDEX_BITS)) u_tags (.*);

    dcache_data_store #(.OFFSET_BITS(OFFSET_BITS), .INDEX_BITS(INDEX_BITS)) u_data (.*);

    dcache_axi_burst #(.OFFSET_BITS(OFFSET_BITS), .INDEX_BITS(INDEX_BITS)) u_axi (
        .xfer (xfer.engine),
        .*
    );

endmodule

`default_nettype wire

/* rtl/dcache_axi_burst.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_axi_burst import dcache_pkg::*; #(
    parameter int OFFSET_BITS = 5,
    parameter int INDEX_BITS  = 7
) (
    input  logic              clk,
    input  logic              rst,
    line_xfer_if.engine       xfer,
    output logic [ADDR_W-1:0] araddr,
    output logic [7:0]        arlen,
    output logic              arvalid,
    input  logic              arready,
    input  word_t             rdata_m,
    input  logic              rlast,
    input  logic              rvalid,
    output logic              rready,
    output logic [ADDR_W-1:0] awaddr,
    output logic [7:0]        awlen,
    output logic              awvalid,
    input  logic              awready,
    output word_t             wdata_m,
    output logic              wlast,
    output logic              wvalid,
    input  logic              wready,
    input  logic              bvalid,
    output logic              bready
);

    localparam int TAG_W  = ADDR_W - OFFSET_BITS - INDEX_BITS;
    localparam int WSEL_W = OFFSET_BITS - 2;
    localparam int WORDS  = 1 << WSEL_W;
    localparam logic [WSEL_W-1:0] PENULT = WSEL_W'(WORDS - 2);

    typedef enum logic [1:0] {E_IDLE, E_ADDR, E_DATA, E_RESP} eng_state_t;

    eng_state_t                  state;
    xfer_op_t                    op_q;
    logic [TAG_W+INDEX_BITS-1:0] line_q;
    logic [WSEL_W-1:0]           beat;
    logic                        done_q;

    assign araddr  = {line_q, {OFFSET_BITS{1'b0}}};
    assign awaddr  = {line_q, {OFFSET_BITS{1'b0}}};
    assign arlen   = 8'(WORDS - 1);
    assign awlen   = 8'(WORDS - 1);
    assign wdata_m = xfer.wr_word;

    assign xfer.beat_idx = beat;
    assign xfer.rd_valid = rvalid && rready;
    assign xfer.rd_word  = rdata_m;
    assign xfer.wr_take  = wvalid && wready;
    assign xfer.done     = done_q;

    always_ff @(posedge clk) begin
        if (state == E_IDLE && xfer.start) begin
            op_q   <= xfer.op;
            line_q <= xfer.line_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= E_IDLE;
            beat    <= '0;
            done_q  <= 1'b0;
            arvalid <= 1'b0;
            rready  <= 1'b0;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            wlast   <= 1'b0;
            bready  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                E_IDLE: begin
                    if (xfer.start) begin
                        beat    <= '0;
                        arvalid <= (xfer.op == XFER_READ);
                        awvalid <= (xfer.op == XFER_WRITE);
                        state   <= E_ADDR;
                    end
                end
                E_ADDR: begin
                    if (arvalid && arready) begin
                        arvalid <= 1'b0;
                        rready  <= 1'b1;
                        state   <= E_DATA;
                    end
                    if (awvalid && awready) begin
                        awvalid <= 1'b0;
                        wvalid  <= 1'b1;
                        state   <= E_DATA;
                    end
                end
                E_DATA: begin
                    if (op_q == XFER_READ) begin
                        if (rvalid && rready) begin
                            beat <= beat + 1'b1;
                            if (rlast) begin
                                rready <= 1'b0;
                                done_q <= 1'b1;
                                state  <= E_IDLE;
                            end
                        end
                    end else if (wvalid && wready) begin
                        beat  <= beat + 1'b1;
                        wlast <= (beat == PENULT);
                        if (wlast) begin
                            wvalid <= 1'b0;
                            wlast  <= 1'b0;
                            bready <= 1'b1;
                            state  <= E_RESP;
                        end
                    end
                end
                default: begin
                    // wait for the write response
                    if (bvalid && bready) begin
                        bready <= 1'b0;
                        done_q <= 1'b1;
                        state  <= E_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/dcache_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_ctrl import dcache_pkg::*; #(
    parameter int OFFSET_BITS = 5,
    parameter int INDEX_BITS  = 7
) (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     req,
    input  logic                                     wr,
    input  logic [ADDR_W-1:0]                        addr,
    input  word_t                                    wdata,
    input  logic [3:0]                               wstrb,
    output logic                                     done,
    output word_t                                    rdata,
    output logic [INDEX_BITS-1:0]                    rd_index,
    output logic [ADDR_W-OFFSET_BITS-INDEX_BITS-1:0] rd_tag,
    input  logic                                     hit,
    input  logic                                     hit_way,
    input  logic                                     victim_way,
    input  logic                                     victim_dirty,
    input  logic [ADDR_W-OFFSET_BITS-INDEX_BITS-1:0] victim_tag,
    output logic                                     upd_en,
    output logic [INDEX_BITS-1:0]                    upd_index,
    output logic                                     upd_way,
    output logic [ADDR_W-OFFSET_BITS-INDEX_BITS-1:0] upd_tag,
    output logic                                     upd_fill,
    output logic                                     upd_dirty,
    output logic [INDEX_BITS+OFFSET_BITS-3:0]        rd_addr,
    output logic                                     rd_way,
    input  word_t                                    rd_word,
    output logic                                     we,
    output logic [INDEX_BITS+OFFSET_BITS-3:0]        wr_addr,
    output logic                                     wr_way,
    output word_t                                    wr_word,
    output logic [3:0]                               wr_strb,
    line_xfer_if.ctrl                                xfer
);

    localparam int TAG_W  = ADDR_W - OFFSET_BITS - INDEX_BITS;
    localparam int WSEL_W = OFFSET_BITS - 2;

    ctrl_state_t state;
    logic        missed;

    logic              req_wr;
    logic [ADDR_W-3:0] req_word_addr;
    word_t             req_wdata;
    logic [3:0]        req_wstrb;
    logic              vic_way;
    word_t             fill_word;

    logic [TAG_W-1:0]      req_tag;
    logic [INDEX_BITS-1:0] req_idx;
    logic [WSEL_W-1:0]     req_wsel;
    word_t                 strb_mask;
    word_t                 fill_merge;
    logic                  fill_hit_word;

    assign {req_tag, req_idx, req_wsel} = req_word_addr;

    // the lookup is read straight from the core address while in IDLE
    assign rd_index = addr[OFFSET_BITS +: INDEX_BITS];
    assign rd_tag   = addr[ADDR_W-1 -: TAG_W];

    assign upd_index = req_idx;
    assign upd_tag   = req_tag;

    assign strb_mask = {{8{req_wstrb[3]}}, {8{req_wstrb[2]}},
                        {8{req_wstrb[1]}}, {8{req_wstrb[0]}}};
    assign fill_hit_word = (xfer.beat_idx == req_wsel);
    // store bytes win over the refilled bytes
    assign fill_merge = (fill_hit_word && req_wr) ?
                        ((xfer.rd_word & ~strb_mask) | (req_wdata & strb_mask)) :
                        xfer.rd_word;

    assign xfer.wr_word = rd_word;
    assign done  = (state == RESPOND);
    assign rdata = missed ? fill_word : rd_word;

    always_comb begin
        rd_addr        = {req_idx, req_wsel};
        rd_way         = vic_way;
        we             = 1'b0;
        wr_addr        = {req_idx, req_wsel};
        wr_way         = vic_way;
        wr_word        = req_wdata;
        wr_strb        = req_wstrb;
        upd_en         = 1'b0;
        upd_way        = vic_way;
        upd_fill       = 1'b0;
        upd_dirty      = req_wr;
        xfer.start     = 1'b0;
        xfer.op        = XFER_READ;
        xfer.line_addr = {req_tag, req_idx};
        case (state)
            LOOKUP: begin
                if (hit) begin
                    rd_way  = hit_way;
                    we      = req_wr;
                    wr_way  = hit_way;
                    upd_en  = 1'b1;
                    upd_way = hit_way;
                end else begin
                    xfer.start = 1'b1;
                    if (victim_dirty) begin
                        xfer.op        = XFER_WRITE;
                        xfer.line_addr = {victim_tag, req_idx};
                    end
                end
            end
            WRITEBACK: begin
                // read one word ahead so wdata follows the accepted beat
                rd_addr    = {req_idx, xfer.beat_idx + WSEL_W'(xfer.wr_take)};
                xfer.start = xfer.done;
            end
            REFILL: begin
                we       = xfer.rd_valid;
                wr_addr  = {req_idx, xfer.beat_idx};
                wr_word  = fill_merge;
                wr_strb  = 4'hf;
                upd_en   = xfer.done;
                upd_fill = 1'b1;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= IDLE;
            missed <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (req) begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    missed <= !hit;
                    if (hit) begin
                        state <= RESPOND;
                    end else if (victim_dirty) begin
                        state <= WRITEBACK;
                    end else begin
                        state <= REFILL;
                    end
                end
                WRITEBACK: begin
                    if (xfer.done) begin
                        state <= REFILL;
                    end
                end
                REFILL: begin
                    if (xfer.done) begin
                        state <= RESPOND;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && req) begin
            req_wr        <= wr;
            req_word_addr <= addr[ADDR_W-1:2];
            req_wdata     <= wdata;
            req_wstrb     <= wstrb;
        end
        if (state == LOOKUP) begin
            vic_way <= victim_way;
        end
        if (state == REFILL && xfer.rd_valid && fill_hit_word) begin
            fill_word <= xfer.rd_word;
        end
    end

endmodule

`default_nettype wire

/* rtl/dcache_data_store.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_data_store import dcache_pkg::*; #(
    parameter int OFFSET_BITS = 5,
    parameter int INDEX_BITS  = 7
) (
    input  logic                              clk,
    input  logic [INDEX_BITS+OFFSET_BITS-3:0] rd_addr,
    input  logic                              rd_way,
    output word_t                             rd_word,
    input  logic                              we,
    input  logic [INDEX_BITS+OFFSET_BITS-3:0] wr_addr,
    input  logic                              wr_way,
    input  word_t                             wr_word,
    input  logic [3:0]                        wr_strb
);

    localparam int DEPTH = 1 << (INDEX_BITS + OFFSET_BITS - 2);

    word_t rd_q [2];
    logic  rd_way_q;

    for (genvar w = 0; w < 2; w++) begin : g_bank
        word_t mem [DEPTH];

        always_ff @(posedge clk) begin
            if (we && (wr_way == 1'(w))) begin
                for (int b = 0; b < 4; b++) begin
                    if (wr_strb[b]) begin
                        mem[wr_addr][8*b +: 8] <= wr_word[8*b +: 8];
                    end
                end
            end
            rd_q[w] <= mem[rd_addr];
        end
    end

    always_ff @(posedge clk) begin
        rd_way_q <= rd_way;
    end

    assign rd_word = rd_q[rd_way_q];

endmodule

`default_nettype wire

/* rtl/dcache_tag_store.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_tag_store import dcache_pkg::*; #(
    parameter int OFFSET_BITS = 5,
    parameter int INDEX_BITS  = 7
) (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic [INDEX_BITS-1:0]                    rd_index,
    input  logic [ADDR_W-OFFSET_BITS-INDEX_BITS-1:0] rd_tag,
    output logic                                     hit,
    output logic                                     hit_way,
    output logic                                     victim_way,
    output logic                                     victim_dirty,
    output logic [ADDR_W-OFFSET_BITS-INDEX_BITS-1:0] victim_tag,
    input  logic                                     upd_en,
    input  logic [INDEX_BITS-1:0]                    upd_index,
    input  logic                                     upd_way,
    input  logic [ADDR_W-OFFSET_BITS-INDEX_BITS-1:0] upd_tag,
    input  logic                                     upd_fill,
    input  logic                                     upd_dirty
);

    localparam int TAG_W = ADDR_W - OFFSET_BITS - INDEX_BITS;
    localparam int SETS  = 1 << INDEX_BITS;

    logic [TAG_W-1:0]     tag_ram [2][SETS];
    logic [1:0][SETS-1:0] valid_q;
    logic [1:0][SETS-1:0] dirty_q;
    // per set, the least recently used way
    logic [SETS-1:0]      lru_q;

    logic [TAG_W-1:0]     tag_r [2];
    logic [TAG_W-1:0]     cmp_tag;
    logic [1:0]           valid_r;
    logic [1:0]           dirty_r;
    logic                 lru_r;
    logic [1:0]           match;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
            valid_r <= '0;
            dirty_r <= '0;
            lru_r   <= 1'b0;
        end else begin
            valid_r <= {valid_q[1][rd_index], valid_q[0][rd_index]};
            dirty_r <= {dirty_q[1][rd_index], dirty_q[0][rd_index]};
            lru_r   <= lru_q[rd_index];
            if (upd_en) begin
                lru_q[upd_index] <= ~upd_way;
                // a fill replaces the dirty bit, a hit can only set it
                if (upd_fill) begin
                    valid_q[upd_way][upd_index] <= 1'b1;
                    dirty_q[upd_way][upd_index] <= upd_dirty;
                end else if (upd_dirty) begin
                    dirty_q[upd_way][upd_index] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        cmp_tag <= rd_tag;
        for (int w = 0; w < 2; w++) begin
            tag_r[w] <= tag_ram[w][rd_index];
        end
        if (upd_en && upd_fill) begin
            tag_ram[upd_way][upd_index] <= upd_tag;
        end
    end

    assign match[0] = valid_r[0] && (tag_r[0] == cmp_tag);
    assign match[1] = valid_r[1] && (tag_r[1] == cmp_tag);

    assign hit          = |match;
    assign hit_way      = match[1];
    assign victim_way   = lru_r;
    assign victim_dirty = valid_r[lru_r] && dirty_r[lru_r];
    assign victim_tag   = tag_r[lru_r];

endmodule

`default_nettype wire

/* rtl/line_xfer_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface line_xfer_if import dcache_pkg::*; #(
    parameter int OFFSET_BITS = 5,
    parameter int INDEX_BITS  = 7
) ();

    localparam int TAG_W  = ADDR_W - OFFSET_BITS - INDEX_BITS;
    localparam int WSEL_W = OFFSET_BITS - 2;

    logic                        start;
    xfer_op_t                    op;
    // line number, tag then index
    logic [TAG_W+INDEX_BITS-1:0] line_addr;
    word_t                       wr_word;

    logic [WSEL_W-1:0]           beat_idx;
    logic                        rd_valid;
    word_t                       rd_word;
    logic                        wr_take;
    logic                        done;

    modport ctrl (
        output start, op, line_addr, wr_word,
        input  beat_idx, rd_valid, rd_word, wr_take, done
    );

    modport engine (
        input  start, op, line_addr, wr_word,
        output beat_idx, rd_valid, rd_word, wr_take, done
    );

endinterface

`default_nettype wire

/* rtl/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    localparam int ADDR_W = 32;

    typedef logic [31:0] word_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL,
        RESPOND
    } ctrl_state_t;

    // direction of a line transfer, seen from the cache
    typedef enum logic {
        XFER_READ  = 1'b0,
        XFER_WRITE = 1'b1
    } xfer_op_t;

endpackage

`default_nettype wire
